//--- compile.f
hdl/conv_pkg.sv
hdl/window_buffer.sv
hdl/kernel_mac.sv
hdl/result_writer.sv
hdl/conv_sequencer.sv
hdl/conv_layer_top.sv
dv/conv_mem_model.sv
dv/conv_layer_assertions.sv
dv/conv_layer_tb.sv

//--- dv/conv_layer_assertions.sv
module conv_layer_assertions import conv_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              fin,
  input logic              mem_wen,
  input logic [ADDR_W-1:0] mem_addr,
  input seq_state_t        seq_state
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count;

  initial begin
    fail_count = 0;
  end

  fin_one_cycle: assert property (@(posedge clk) disable iff (rst) fin |=> !fin)
    else begin
      fail_count++;
      $error("fin stayed high for two cycles");
    end

  // only the output block may be written
  write_in_range: assert property (@(posedge clk) disable iff (rst)
    mem_wen |-> (mem_addr >= O_BASE) && (mem_addr < O_BASE + OUT_W * OUT_H))
    else begin
      fail_count++;
      $error("write to address %h outside the output block", mem_addr);
    end

  no_write_when_idle: assert property (@(posedge clk) disable iff (rst)
    mem_wen |-> seq_state != ST_IDLE)
    else begin
      fail_count++;
      $error("memory written while the sequencer is idle");
    end

endmodule

//--- dv/conv_layer_tb.sv
module conv_layer_tb import conv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIN_TIMEOUT = 2000;
  localparam int N_OUT       = OUT_W * OUT_H;
  localparam int CENTRE      = (KSIZE / 2) * KSIZE + KSIZE / 2;

  logic              clk;
  logic              rst;
  logic              start;
  logic              fin;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_wen;
  logic [WORD_W-1:0] mem_wdata;
  logic [WORD_W-1:0] mem_rdata;

  // image, kernels and biases of the current run
  logic [PIX_W-1:0]         img [IMG_H][IMG_W];
  logic signed [COEF_W-1:0] wt0 [N_TAPS];
  logic signed [COEF_W-1:0] wt1 [N_TAPS];
  logic [COEF_W-1:0]        bias0;
  logic [COEF_W-1:0]        bias1;
  logic [WORD_W-1:0]        shadow [2**ADDR_W];

  int errors;
  int checks;
  int tests_run;

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  conv_layer_top conv_layer_top_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .fin       (fin),
    .mem_addr  (mem_addr),
    .mem_wen   (mem_wen),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  conv_mem_model mem_i (
    .clk   (clk),
    .addr  (mem_addr),
    .wen   (mem_wen),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  bind conv_layer_top conv_layer_assertions conv_layer_assertions_i (
    .clk       (clk),
    .rst       (rst),
    .fin       (fin),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .seq_state (conv_sequencer_i.state)
  );

  function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a, ~a, a ^ 8'h5a, 8'hc3};
  endfunction

  task automatic mem_put(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
    mem_i.backdoor_write(a, d);
    shadow[a] = d;
  endtask

  task automatic load_memory();
    logic [WORD_W-1:0] w;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem_put(ADDR_W'(a), fill_word(ADDR_W'(a)));
    end
    // leftmost pixel in the low byte
    for (int r = 0; r < IMG_H; r++) begin
      for (int k = 0; k < ROW_WORDS; k++) begin
        for (int p = 0; p < PIX_PER_WORD; p++) begin
          w[p * PIX_W +: PIX_W] = img[r][k * PIX_PER_WORD + p];
        end
        mem_put(IMG_BASE + ADDR_W'(r * ROW_WORDS + k), w);
      end
    end
    for (int i = 0; i < N_TAPS; i++) begin
      mem_put(W_BASE + ADDR_W'(i), {wt1[i], wt0[i]});
    end
    mem_put(B_BASE, {bias1, bias0});
  endtask

  task automatic randomize_image();
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        img[r][c] = PIX_W'($urandom);
      end
    end
  endtask

  task automatic randomize_weights();
    for (int i = 0; i < N_TAPS; i++) begin
      wt0[i] = COEF_W'($urandom);
      wt1[i] = COEF_W'($urandom);
    end
  endtask

  task automatic clear_kernels();
    for (int i = 0; i < N_TAPS; i++) begin
      wt0[i] = '0;
      wt1[i] = '0;
    end
    bias0 = '0;
    bias1 = '0;
  endtask

  // expected output word from the convolution rule
  function automatic logic [WORD_W-1:0] expected_word(input int orow, input int ocol);
    int acc0;
    int acc1;
    logic [COEF_W-1:0] res0;
    logic [COEF_W-1:0] res1;
    acc0 = 0;
    acc1 = 0;
    for (int r = 0; r < KSIZE; r++) begin
      for (int c = 0; c < KSIZE; c++) begin
        acc0 += int'(wt0[r * KSIZE + c]) * int'(img[orow + r][ocol + c]);
        acc1 += int'(wt1[r * KSIZE + c]) * int'(img[orow + r][ocol + c]);
      end
    end
    res0 = COEF_W'(acc0 >>> RES_LSB) + bias0;
    res1 = COEF_W'(acc1 >>> RES_LSB) + bias1;
    return {res0, res1};
  endfunction

  task automatic check_value(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // output block against the model and every other word against its fill
  task automatic check_memory(input string name);
    logic [WORD_W-1:0] exp;
    int idx;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      idx = a - int'(O_BASE);
      if (idx >= 0 && idx < N_OUT) begin
        exp = expected_word(idx / OUT_W, idx % OUT_W);
      end else begin
        exp = shadow[a];
      end
      check_value(mem_i.backdoor_read(ADDR_W'(a)), exp,
                  $sformatf("%s word at 0x%02h", name, a));
    end
  endtask

  task automatic run_engine(input string name);
    int cycles;
    bit seen;
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < FIN_TIMEOUT) begin
      if (fin) begin
        seen = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
    if (!seen) begin
      $display("no fin from the engine within %0d cycles in test %s", FIN_TIMEOUT, name);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    $display("test %s done, %0d errors", name, errors - err0);
  endtask

  task automatic test_idle_after_reset();
    int err0;
    err0 = errors;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      #1;
      check_value({31'b0, fin}, '0, $sformatf("fin in idle cycle %0d", i));
      check_value({31'b0, mem_wen}, '0, $sformatf("mem_wen in idle cycle %0d", i));
    end
    report_test("idle_after_reset", err0);
  endtask

  task automatic test_identity();
    int err0;
    logic [PIX_W-1:0] p;
    err0 = errors;
    randomize_image();
    clear_kernels();
    wt0[CENTRE] = 16'sd256;
    wt1[CENTRE] = 16'sd256;
    load_memory();
    run_engine("identity");
    for (int i = 0; i < N_OUT; i++) begin
      p = img[i / OUT_W + KSIZE / 2][i % OUT_W + KSIZE / 2];
      check_value(mem_i.backdoor_read(O_BASE + ADDR_W'(i)), {8'h00, p, 8'h00, p},
                  $sformatf("identity position %0d", i));
    end
    check_memory("identity");
    report_test("identity", err0);
  endtask

  task automatic test_random_weights();
    int err0;
    err0 = errors;
    randomize_image();
    clear_kernels();
    randomize_weights();
    load_memory();
    run_engine("random_weights");
    check_memory("random_weights");
    report_test("random_weights", err0);
  endtask

  task automatic test_bias_wrap();
    int err0;
    logic [PIX_W-1:0] p;
    logic [WORD_W-1:0] got;
    err0 = errors;
    randomize_image();
    img[KSIZE / 2][KSIZE / 2] = 8'hff;
    clear_kernels();
    wt0[CENTRE] = 16'sd256;
    wt0[0]      = 16'sd64;
    wt1[CENTRE] = -16'sd256;
    bias0 = 16'hff80;
    // minus pixel plus 0x100 carries out of 16 bits
    bias1 = 16'h0100;
    load_memory();
    run_engine("bias_wrap");
    for (int i = 0; i < N_OUT; i++) begin
      p = img[i / OUT_W + KSIZE / 2][i % OUT_W + KSIZE / 2];
      got = mem_i.backdoor_read(O_BASE + ADDR_W'(i));
      check_value({16'h0, got[COEF_W-1:0]}, {16'h0, 16'h0100 - {8'h00, p}},
                  $sformatf("channel 1 wrap position %0d", i));
    end
    check_memory("bias_wrap");
    report_test("bias_wrap", err0);
  endtask

  task automatic test_back_to_back();
    int err0;
    err0 = errors;
    randomize_weights();
    bias0 = COEF_W'($urandom);
    bias1 = COEF_W'($urandom);
    load_memory();
    run_engine("back_to_back");
    check_memory("back_to_back");
    report_test("back_to_back", err0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests_run = 0;
    rst = 1'b1;
    start = 1'b0;
    void'($urandom(62672));
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_idle_after_reset();
    test_identity();
    test_random_weights();
    test_bias_wrap();
    test_back_to_back();
    errors += conv_layer_top_i.conv_layer_assertions_i.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests_run, checks,
             errors, conv_layer_top_i.conv_layer_assertions_i.fail_count);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- dv/conv_mem_model.sv
module conv_mem_model import conv_pkg::*; (
  input  logic              clk,
  input  logic [ADDR_W-1:0] addr,
  input  logic              wen,
  input  logic [WORD_W-1:0] wdata,
  output logic [WORD_W-1:0] rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [WORD_W-1:0] mem [2**ADDR_W];

  initial begin
    rdata = '0;
  end

  // read data shows up one cycle after the address, old word on a write
  always @(posedge clk) begin
    if (wen) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  task automatic backdoor_write(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
    mem[a] = d;
  endtask

  function automatic logic [WORD_W-1:0] backdoor_read(input logic [ADDR_W-1:0] a);
    return mem[a];
  endfunction

endmodule

//--- hdl/conv_layer_top.sv
module conv_layer_top import conv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic              fin,
  output logic [ADDR_W-1:0] mem_addr,
  output logic              mem_wen,
  output logic [WORD_W-1:0] mem_wdata,
  input  logic [WORD_W-1:0] mem_rdata
);

  logic [ADDR_W-1:0]             rd_addr;
  logic [ADDR_W-1:0]             wr_addr;
  logic                          write_grant;
  logic                          weight_we;
  logic [4:0]                    weight_idx;
  logic                          bias_we;
  logic                          fetch_we;
  logic [2:0]                    row_sel;
  logic                          half_sel;
  logic                          shift;
  logic                          compute;
  logic [N_TAPS-1:0][PIX_W-1:0]  window;
  logic                          result_valid_0;
  logic                          result_valid_1;
  logic [COEF_W-1:0]             result_0;
  logic [COEF_W-1:0]             result_1;
  logic                          queue_empty;

  // single port shared between reads and result writes
  assign mem_addr = write_grant ? wr_addr : rd_addr;

  conv_sequencer conv_sequencer_i (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .queue_empty (queue_empty),
    .rd_addr     (rd_addr),
    .write_grant (write_grant),
    .weight_we   (weight_we),
    .weight_idx  (weight_idx),
    .bias_we     (bias_we),
    .fetch_we    (fetch_we),
    .row_sel     (row_sel),
    .half_sel    (half_sel),
    .shift       (shift),
    .compute     (compute),
    .fin         (fin)
  );

  window_buffer window_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .fetch_we  (fetch_we),
    .row_sel   (row_sel),
    .half_sel  (half_sel),
    .shift     (shift),
    .mem_rdata (mem_rdata),
    .window    (window)
  );

  kernel_mac #(.CHANNEL(0)) kernel_mac_0_i (
    .clk          (clk),
    .rst          (rst),
    .weight_we    (weight_we),
    .weight_idx   (weight_idx),
    .mem_rdata    (mem_rdata),
    .compute      (compute),
    .window       (window),
    .result_valid (result_valid_0),
    .result       (result_0)
  );

  kernel_mac #(.CHANNEL(1)) kernel_mac_1_i (
    .clk          (clk),
    .rst          (rst),
    .weight_we    (weight_we),
    .weight_idx   (weight_idx),
    .mem_rdata    (mem_rdata),
    .compute      (compute),
    .window       (window),
    .result_valid (result_valid_1),
    .result       (result_1)
  );

  result_writer result_writer_i (
    .clk            (clk),
    .rst            (rst),
    .bias_we        (bias_we),
    .mem_rdata      (mem_rdata),
    .result_valid_0 (result_valid_0),
    .result_valid_1 (result_valid_1),
    .result_0       (result_0),
    .result_1       (result_1),
    .write_grant    (write_grant),
    .start          (start),
    .queue_empty    (queue_empty),
    .wr_addr        (wr_addr),
    .mem_wen        (mem_wen),
    .mem_wdata      (mem_wdata)
  );

endmodule

//--- hdl/conv_pkg.sv
package conv_pkg;

  // image and kernel geometry
  localparam int IMG_W        = 16;
  localparam int IMG_H        = 8;
  localparam int KSIZE        = 5;
  localparam int N_TAPS       = KSIZE * KSIZE;
  localparam int PIX_PER_WORD = 4;
  localparam int ROW_WORDS    = IMG_W / PIX_PER_WORD;
  localparam int OUT_W        = IMG_W - KSIZE + 1;
  localparam int OUT_H        = IMG_H - KSIZE + 1;

  // datapath widths
  localparam int ADDR_W  = 8;
  localparam int WORD_W  = 32;
  localparam int PIX_W   = 8;
  localparam int COEF_W  = 16;
  localparam int ACC_W   = 32;
  localparam int RES_LSB = 8;

  // memory map
  localparam logic [ADDR_W-1:0] IMG_BASE = 8'h00;
  localparam logic [ADDR_W-1:0] W_BASE   = 8'h40;
  localparam logic [ADDR_W-1:0] B_BASE   = 8'h59;
  localparam logic [ADDR_W-1:0] O_BASE   = 8'h80;

  localparam int QUEUE_DEPTH = 8;

  // compute strobe register, three mac stages, queue entry
  localparam int DRAIN_WAIT = 5;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_PRIME,
    ST_FETCH,
    ST_COMPUTE,
    ST_DRAIN,
    ST_DONE
  } seq_state_t;

endpackage

//--- hdl/conv_sequencer.sv
module conv_sequencer import conv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              queue_empty,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              write_grant,
  output logic              weight_we,
  output logic [4:0]        weight_idx,
  output logic              bias_we,
  output logic              fetch_we,
  output logic [2:0]        row_sel,
  output logic              half_sel,
  output logic              shift,
  output logic              compute,
  output logic              fin
);

  seq_state_t                     state;
  logic [4:0]                     cnt;
  logic [$clog2(OUT_H)-1:0]       row;
  logic [$clog2(ROW_WORDS)-1:0]   word;
  logic [$clog2(OUT_W)-1:0]       col;
  logic [ADDR_W-1:0]              img_row;
  logic                           last_col;
  logic                           last_row;
  logic                           drain_done;

  assign last_col   = (col == OUT_W - 1);
  assign last_row   = (row == OUT_H - 1);
  assign drain_done = (cnt == DRAIN_WAIT) && queue_empty;

  // port belongs to the writer outside of reads
  assign write_grant = (state == ST_COMPUTE) || (state == ST_DRAIN) || (state == ST_DONE);

  // image row read in this fetch cycle
  assign img_row = ADDR_W'(row) + ADDR_W'(cnt);

  always_comb begin
    case (state)
      ST_LOAD:  rd_addr = (cnt == N_TAPS) ? B_BASE : W_BASE + ADDR_W'(cnt);
      ST_PRIME: rd_addr = IMG_BASE + img_row * ADDR_W'(ROW_WORDS);
      ST_FETCH: rd_addr = IMG_BASE + img_row * ADDR_W'(ROW_WORDS) + ADDR_W'(word);
      default:  rd_addr = IMG_BASE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
      row   <= '0;
      word  <= '0;
      col   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          cnt <= '0;
          if (start) begin
            state <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (cnt == N_TAPS) begin
            state <= ST_PRIME;
            cnt   <= '0;
            row   <= '0;
            col   <= '0;
          end else begin
            cnt <= cnt + 5'd1;
          end
        end
        ST_PRIME: begin
          if (cnt == KSIZE - 1) begin
            state <= ST_FETCH;
            cnt   <= '0;
            word  <= 1;
          end else begin
            cnt <= cnt + 5'd1;
          end
        end
        ST_FETCH: begin
          if (cnt == KSIZE - 1) begin
            state <= ST_COMPUTE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 5'd1;
          end
        end
        ST_COMPUTE: begin
          col <= col + 1'b1;
          cnt <= cnt + 5'd1;
          if (last_col) begin
            cnt <= '0;
            col <= '0;
            if (last_row) begin
              state <= ST_DRAIN;
            end else begin
              state <= ST_PRIME;
              row   <= row + 1'b1;
            end
          end else if (cnt == PIX_PER_WORD - 1) begin
            // half 1 has moved into half 0, refill half 1
            state <= ST_FETCH;
            cnt   <= '0;
            word  <= word + 1'b1;
          end
        end
        ST_DRAIN: begin
          // results still in the mac pipeline do not show in queue_empty
          if (cnt < DRAIN_WAIT) begin
            cnt <= cnt + 5'd1;
          end
          if (drain_done) begin
            state <= ST_DONE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // strobes trail the state by one cycle, matching read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      weight_we  <= 1'b0;
      weight_idx <= '0;
      bias_we    <= 1'b0;
      fetch_we   <= 1'b0;
      row_sel    <= '0;
      half_sel   <= 1'b0;
      shift      <= 1'b0;
      compute    <= 1'b0;
      fin        <= 1'b0;
    end else begin
      weight_we  <= (state == ST_LOAD) && (cnt < N_TAPS);
      weight_idx <= cnt;
      bias_we    <= (state == ST_LOAD) && (cnt == N_TAPS);
      fetch_we   <= (state == ST_PRIME) || (state == ST_FETCH);
      row_sel    <= cnt[2:0];
      half_sel   <= (state == ST_FETCH);
      shift      <= (state == ST_COMPUTE);
      compute    <= (state == ST_COMPUTE);
      fin        <= (state == ST_DRAIN) && drain_done;
    end
  end

endmodule

//--- hdl/kernel_mac.sv
module kernel_mac import conv_pkg::*; #(
  parameter int CHANNEL = 0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         weight_we,
  input  logic [4:0]                   weight_idx,
  input  logic [WORD_W-1:0]            mem_rdata,
  input  logic                         compute,
  input  logic [N_TAPS-1:0][PIX_W-1:0] window,
  output logic                         result_valid,
  output logic [COEF_W-1:0]            result
);

  logic signed [COEF_W-1:0] weight [N_TAPS];
  logic signed [ACC_W-1:0]  prod [N_TAPS];
  logic signed [ACC_W-1:0]  row_sum_d [KSIZE];
  logic signed [ACC_W-1:0]  row_sum [KSIZE];
  logic signed [ACC_W-1:0]  total_d;
  logic signed [ACC_W-1:0]  total;
  logic [2:0]               valid_pipe;

  // channel 0 in the low half of each weight word
  always_ff @(posedge clk) begin
    if (weight_we) begin
      weight[weight_idx] <= mem_rdata[CHANNEL * COEF_W +: COEF_W];
    end
  end

  // stage 1, pixels zero extended
  always_ff @(posedge clk) begin
    if (compute) begin
      for (int i = 0; i < N_TAPS; i++) begin
        prod[i] <= weight[i] * $signed({1'b0, window[i]});
      end
    end
  end

  always_comb begin
    for (int r = 0; r < KSIZE; r++) begin
      row_sum_d[r] = '0;
      for (int c = 0; c < KSIZE; c++) begin
        row_sum_d[r] = row_sum_d[r] + prod[r * KSIZE + c];
      end
    end
  end

  always_comb begin
    total_d = '0;
    for (int r = 0; r < KSIZE; r++) begin
      total_d = total_d + row_sum[r];
    end
  end

  // stages 2 and 3
  always_ff @(posedge clk) begin
    if (valid_pipe[0]) begin
      row_sum <= row_sum_d;
    end
    if (valid_pipe[1]) begin
      total <= total_d;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[1:0], compute};
    end
  end

  assign result_valid = valid_pipe[2];
  assign result       = total[RES_LSB +: COEF_W];

endmodule

//--- hdl/result_writer.sv
module result_writer import conv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              bias_we,
  input  logic [WORD_W-1:0] mem_rdata,
  input  logic              result_valid_0,
  input  logic              result_valid_1,
  input  logic [COEF_W-1:0] result_0,
  input  logic [COEF_W-1:0] result_1,
  input  logic              write_grant,
  input  logic              start,
  output logic              queue_empty,
  output logic [ADDR_W-1:0] wr_addr,
  output logic              mem_wen,
  output logic [WORD_W-1:0] mem_wdata
);

  logic [COEF_W-1:0]                bias_0;
  logic [COEF_W-1:0]                bias_1;
  logic [COEF_W-1:0]                sum_0;
  logic [COEF_W-1:0]                sum_1;
  logic [WORD_W-1:0]                queue [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0]   head;
  logic [$clog2(QUEUE_DEPTH)-1:0]   tail;
  logic [$clog2(QUEUE_DEPTH):0]     count;
  logic                             push;
  logic                             pop;

  always_ff @(posedge clk) begin
    if (bias_we) begin
      bias_0 <= mem_rdata[COEF_W-1:0];
      bias_1 <= mem_rdata[WORD_W-1:COEF_W];
    end
  end

  // wraps in 16 bits
  assign sum_0 = result_0 + bias_0;
  assign sum_1 = result_1 + bias_1;

  assign push        = result_valid_0 & result_valid_1;
  assign queue_empty = (count == '0);
  assign pop         = write_grant & ~queue_empty;

  assign mem_wen   = pop;
  assign mem_wdata = queue[head];

  // channel 0 goes to the upper half
  always_ff @(posedge clk) begin
    if (push) begin
      queue[tail] <= {sum_0, sum_1};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // every run writes from O_BASE again
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_addr <= O_BASE;
    end else if (start) begin
      wr_addr <= O_BASE;
    end else if (pop) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

//--- hdl/window_buffer.sv
module window_buffer import conv_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fetch_we,
  input  logic [2:0]                   row_sel,
  input  logic                         half_sel,
  input  logic                         shift,
  input  logic [WORD_W-1:0]            mem_rdata,
  output logic [N_TAPS-1:0][PIX_W-1:0] window
);

  // two words per row, pixel 0 is the leftmost column
  logic [KSIZE-1:0][2*PIX_PER_WORD-1:0][PIX_W-1:0] pix;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pix <= '0;
    end else if (fetch_we) begin
      // low byte holds the leftmost pixel of the word
      for (int p = 0; p < PIX_PER_WORD; p++) begin
        pix[row_sel][half_sel * PIX_PER_WORD + p] <= mem_rdata[p * PIX_W +: PIX_W];
      end
    end else if (shift) begin
      for (int r = 0; r < KSIZE; r++) begin
        pix[r] <= pix[r] >> PIX_W;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < KSIZE; r++) begin
      for (int c = 0; c < KSIZE; c++) begin
        window[r * KSIZE + c] = pix[r][c];
      end
    end
  end

endmodule
